/* hdl/basicOps.sv */
module basicOps import g729Pkg::*; (
	input logic signed [wordWidth-1:0] subA,
	input logic signed [wordWidth-1:0] subB,
	input logic signed [longWidth-1:0] lSubA,
	input logic signed [longWidth-1:0] lSubB,
	input logic signed [wordWidth-1:0] addA,
	input logic signed [wordWidth-1:0] addB,
	input logic signed [wordWidth-1:0] shlVar1,
	input logic signed [wordWidth-1:0] shlVar2,
	input logic signed [longWidth-1:0] lShrVar1,
	input logic signed [wordWidth-1:0] lShrShift,
	input logic signed [wordWidth-1:0] multA,
	input logic signed [wordWidth-1:0] multB,
	input logic signed [wordWidth-1:0] lMultA,
	input logic signed [wordWidth-1:0] lMultB,
	output logic signed [wordWidth-1:0] subOut,
	output logic signed [longWidth-1:0] lSubOut,
	output logic signed [wordWidth-1:0] addOut,
	output logic signed [wordWidth-1:0] shlOut,
	output logic signed [longWidth-1:0] lShrOut,
	output logic signed [wordWidth-1:0] multOut,
	output logic signed [longWidth-1:0] lMultOut
);

	localparam logic signed [wordWidth-1:0] maxWord = 16'sh7fff;
	localparam logic signed [wordWidth-1:0] minWord = 16'sh8000;
	localparam logic signed [longWidth-1:0] maxLong = 32'sh7fff_ffff;
	localparam logic signed [longWidth-1:0] minLong = 32'sh8000_0000;

	logic signed [wordWidth:0] subWide;
	logic signed [wordWidth:0] addWide;
	logic signed [longWidth:0] lSubWide;
	logic signed [2*wordWidth-1:0] multProd;
	logic signed [2*wordWidth-1:0] lMultProd;
	logic [wordWidth:0] shlMag;
	logic signed [2*wordWidth-1:0] shlWide;
	logic [wordWidth:0] lShlMag;
	logic signed [2*longWidth-1:0] lShlWide;

	// Clamp a one-bit-wider result whose top two bits differ on overflow
	function automatic logic signed [wordWidth-1:0] satWord(input logic signed [wordWidth:0] v);
		if (v[wordWidth] != v[wordWidth-1])
			return v[wordWidth] ? minWord : maxWord;
		return v[wordWidth-1:0];
	endfunction

	function automatic logic signed [longWidth-1:0] satLong(input logic signed [longWidth:0] v);
		if (v[longWidth] != v[longWidth-1])
			return v[longWidth] ? minLong : maxLong;
		return v[longWidth-1:0];
	endfunction

	assign subWide = {subA[wordWidth-1], subA} - {subB[wordWidth-1], subB};
	assign addWide = {addA[wordWidth-1], addA} + {addB[wordWidth-1], addB};
	assign lSubWide = {lSubA[longWidth-1], lSubA} - {lSubB[longWidth-1], lSubB};

	assign subOut = satWord(subWide);
	assign addOut = satWord(addWide);
	assign lSubOut = satLong(lSubWide);

	// Only -32768 * -32768 overflows either multiply
	assign multProd = multA * multB;
	assign multOut = satWord(multProd[2*wordWidth-1:wordWidth-1]);

	assign lMultProd = lMultA * lMultB;
	assign lMultOut = (lMultProd == 32'sh4000_0000) ? maxLong : {lMultProd[longWidth-2:0], 1'b0};

	////////////////////////////////////////
	// Shifts that reverse on negative counts
	////////////////////////////////////////

	always_comb
	begin
		shlMag = -{shlVar2[wordWidth-1], shlVar2};
		shlWide = {{wordWidth{shlVar1[wordWidth-1]}}, shlVar1} << shlVar2[3:0];
		if (shlVar2[wordWidth-1])
		begin
			if (shlMag >= wordWidth - 1)
				shlOut = {wordWidth{shlVar1[wordWidth-1]}};
			else
				shlOut = shlVar1 >>> shlMag[3:0];
		end
		else if (shlVar2 > wordWidth - 1)
			shlOut = (shlVar1 == '0) ? '0 : (shlVar1[wordWidth-1] ? minWord : maxWord);
		else if (shlWide[2*wordWidth-1:wordWidth-1] == {(wordWidth+1){shlWide[wordWidth-1]}})
			shlOut = shlWide[wordWidth-1:0];
		else
			shlOut = shlVar1[wordWidth-1] ? minWord : maxWord;
	end

	always_comb
	begin
		lShlMag = -{lShrShift[wordWidth-1], lShrShift};
		lShlWide = {{longWidth{lShrVar1[longWidth-1]}}, lShrVar1} << lShlMag[4:0];
		if (lShrShift[wordWidth-1])
		begin
			// Left shift with saturation
			if (lShlMag > longWidth - 1)
				lShrOut = (lShrVar1 == '0) ? '0 : (lShrVar1[longWidth-1] ? minLong : maxLong);
			else if (lShlWide[2*longWidth-1:longWidth-1] == {(longWidth+1){lShlWide[longWidth-1]}})
				lShrOut = lShlWide[longWidth-1:0];
			else
				lShrOut = lShrVar1[longWidth-1] ? minLong : maxLong;
		end
		else if (lShrShift >= longWidth - 1)
			lShrOut = {longWidth{lShrVar1[longWidth-1]}};
		else
			lShrOut = lShrVar1 >>> lShrShift[4:0];
	end

endmodule

/* hdl/constantRom.sv */
module constantRom import g729Pkg::*; (
	input logic clk,
	input logic [romAddrWidth-1:0] addr,
	output logic [longWidth-1:0] data
);

	// table2 then slope_acos
	localparam int tableWords = 128;

	logic [longWidth-1:0] rom [0:2**romAddrWidth-1];

	initial
	begin
		$readmemh("hdl/lspTables.hex", rom, 0, tableWords - 1);
	end

	always_ff @(posedge clk)
	begin
		data <= rom[addr];
	end

endmodule

/* hdl/g729Pkg.sv */
package g729Pkg;

	// Word sizes of the ITU basic operators
	localparam int wordWidth = 16;
	localparam int longWidth = 32;

	localparam int romAddrWidth = 12;

	// Table regions of 64 entries each in the constant ROM
	localparam logic [romAddrWidth-1:0] table2Base = 12'h000;
	localparam logic [romAddrWidth-1:0] slopeAcosBase = 12'h040;

	////////////////////////////////////////
	// Conversion constants
	////////////////////////////////////////

	// 2*pi scaling of the final frequency
	localparam logic signed [wordWidth-1:0] lsfScale = 16'sd25736;

	localparam int lspOrder = 10;

	localparam logic signed [wordWidth-1:0] slopeShift = 16'sd12;
	localparam logic signed [wordWidth-1:0] indShift = 16'sd9;

endpackage

/* hdl/lspLsfConverter.sv */
module lspLsfConverter import g729Pkg::*; #(
	parameter int addrWidth = 12
) (
	input logic clk,
	input logic reset,
	input logic start,
	input logic [addrWidth-1:0] lspAddr,
	input logic [addrWidth-1:0] lsfAddr,
	input logic [longWidth-1:0] memIn,
	input logic [longWidth-1:0] constantMemIn,
	input logic [wordWidth-1:0] subOut,
	input logic [longWidth-1:0] lSubOut,
	input logic [wordWidth-1:0] addOut,
	input logic [wordWidth-1:0] shlOut,
	input logic [longWidth-1:0] lShrOut,
	input logic [wordWidth-1:0] multOut,
	input logic [longWidth-1:0] lMultOut,
	output logic [wordWidth-1:0] subA,
	output logic [wordWidth-1:0] subB,
	output logic [longWidth-1:0] lSubA,
	output logic [longWidth-1:0] lSubB,
	output logic [wordWidth-1:0] addA,
	output logic [wordWidth-1:0] addB,
	output logic [wordWidth-1:0] shlVar1,
	output logic [wordWidth-1:0] shlVar2,
	output logic [longWidth-1:0] lShrVar1,
	output logic [wordWidth-1:0] lShrShift,
	output logic [wordWidth-1:0] multA,
	output logic [wordWidth-1:0] multB,
	output logic [wordWidth-1:0] lMultA,
	output logic [wordWidth-1:0] lMultB,
	output logic [addrWidth-1:0] memReadAddr,
	output logic [addrWidth-1:0] memWriteAddr,
	output logic [longWidth-1:0] memOut,
	output logic memWriteEn,
	output logic [romAddrWidth-1:0] constantMemAddr,
	output logic busy,
	output logic done
);

	typedef enum logic [2:0] {
		idleState,
		addrState,
		searchState,
		offsetState,
		productState,
		writeState,
		doneState
	} stateType;

	stateType state, nextState;
	logic [3:0] i, nextI;
	logic [5:0] ind, nextInd;
	logic [wordWidth-1:0] offset;
	logic [wordWidth-1:0] temp;
	logic [longWidth-1:0] lTemp;

	assign busy = (state != idleState);
	assign done = (state == doneState);

	////////////////////////////////////////
	// Registers
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= idleState;
			i <= 4'(lspOrder - 1);
			ind <= 6'd63;
		end
		else
		begin
			state <= nextState;
			i <= nextI;
			ind <= nextInd;
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == offsetState)
			offset <= subOut;
		if (state == productState)
		begin
			lTemp <= lShrOut;
			temp <= shlOut;
		end
	end

	////////////////////////////////////////
	// Next state and operator steering
	////////////////////////////////////////

	always_comb
	begin
		nextState = state;
		nextI = i;
		nextInd = ind;
		subA = '0;
		subB = '0;
		lSubA = '0;
		lSubB = '0;
		addA = '0;
		addB = '0;
		shlVar1 = '0;
		shlVar2 = '0;
		lShrVar1 = '0;
		lShrShift = '0;
		multA = '0;
		multB = '0;
		lMultA = '0;
		lMultB = '0;
		memReadAddr = '0;
		memWriteAddr = '0;
		memOut = '0;
		memWriteEn = 1'b0;
		constantMemAddr = '0;

		unique case (state)
			idleState:
			begin
				if (start)
				begin
					nextI = 4'(lspOrder - 1);
					nextInd = 6'd63;
					nextState = addrState;
				end
			end

			// Fetch lsp[i] and table2[ind]
			addrState:
			begin
				memReadAddr = {lspAddr[addrWidth-1:4], i};
				constantMemAddr = {table2Base[romAddrWidth-1:6], ind};
				nextState = searchState;
			end

			// Step ind down while table2[ind] < lsp[i] and stop at 0
			searchState:
			begin
				if (ind == '0)
					nextState = offsetState;
				else
				begin
					subA = constantMemIn[wordWidth-1:0];
					subB = memIn[wordWidth-1:0];
					if (subOut[wordWidth-1])
					begin
						lSubA = longWidth'(ind);
						lSubB = 32'd1;
						nextInd = lSubOut[5:0];
					end
					else
						nextState = offsetState;
				end
				// Keep both reads live for the next cycle
				memReadAddr = {lspAddr[addrWidth-1:4], i};
				constantMemAddr = {table2Base[romAddrWidth-1:6], nextInd};
			end

			offsetState:
			begin
				subA = memIn[wordWidth-1:0];
				subB = constantMemIn[wordWidth-1:0];
				constantMemAddr = {slopeAcosBase[romAddrWidth-1:6], ind};
				nextState = productState;
			end

			// Slope term and the coarse index term in parallel
			productState:
			begin
				lMultA = constantMemIn[wordWidth-1:0];
				lMultB = offset;
				lShrVar1 = lMultOut;
				lShrShift = slopeShift;
				shlVar1 = wordWidth'(ind);
				shlVar2 = indShift;
				nextState = writeState;
			end

			writeState:
			begin
				addA = temp;
				addB = lTemp[wordWidth-1:0];
				multA = addOut;
				multB = lsfScale;
				memOut = {{(longWidth-wordWidth){1'b0}}, multOut};
				memWriteEn = 1'b1;
				memWriteAddr = {lsfAddr[addrWidth-1:4], i};
				subA = wordWidth'(i);
				subB = 16'd1;
				nextI = subOut[3:0];
				nextState = (i == '0) ? doneState : addrState;
			end

			doneState:
				nextState = idleState;

			default:
				nextState = idleState;
		endcase
	end

endmodule

/* hdl/lspLsfTop.sv */
module lspLsfTop import g729Pkg::*; #(
	parameter int addrWidth = 12
) (
	input logic clk,
	input logic reset,
	input logic start,
	input logic [addrWidth-1:0] lspAddr,
	input logic [addrWidth-1:0] lsfAddr,
	input logic [addrWidth-1:0] hostAddr,
	input logic [longWidth-1:0] hostWrData,
	input logic hostWrEn,
	output logic [longWidth-1:0] hostRdData,
	output logic busy,
	output logic done
);

	// Operator operands and results
	logic [wordWidth-1:0] subA, subB, subOut;
	logic [longWidth-1:0] lSubA, lSubB, lSubOut;
	logic [wordWidth-1:0] addA, addB, addOut;
	logic [wordWidth-1:0] shlVar1, shlVar2, shlOut;
	logic [longWidth-1:0] lShrVar1, lShrOut;
	logic [wordWidth-1:0] lShrShift;
	logic [wordWidth-1:0] multA, multB, multOut;
	logic [wordWidth-1:0] lMultA, lMultB;
	logic [longWidth-1:0] lMultOut;

	// Memory side
	logic [addrWidth-1:0] memReadAddr, memWriteAddr;
	logic [longWidth-1:0] memIn, memOut;
	logic memWriteEn;
	logic [romAddrWidth-1:0] constantMemAddr;
	logic [longWidth-1:0] constantMemIn;

	lspLsfConverter #(.addrWidth(addrWidth)) converter (
		.clk(clk), .reset(reset), .start(start),
		.lspAddr(lspAddr), .lsfAddr(lsfAddr),
		.memIn(memIn), .constantMemIn(constantMemIn),
		.subOut(subOut), .lSubOut(lSubOut), .addOut(addOut), .shlOut(shlOut),
		.lShrOut(lShrOut), .multOut(multOut), .lMultOut(lMultOut),
		.subA(subA), .subB(subB), .lSubA(lSubA), .lSubB(lSubB),
		.addA(addA), .addB(addB), .shlVar1(shlVar1), .shlVar2(shlVar2),
		.lShrVar1(lShrVar1), .lShrShift(lShrShift),
		.multA(multA), .multB(multB), .lMultA(lMultA), .lMultB(lMultB),
		.memReadAddr(memReadAddr), .memWriteAddr(memWriteAddr),
		.memOut(memOut), .memWriteEn(memWriteEn),
		.constantMemAddr(constantMemAddr), .busy(busy), .done(done)
	);

	basicOps ops (
		.subA(subA), .subB(subB), .lSubA(lSubA), .lSubB(lSubB),
		.addA(addA), .addB(addB), .shlVar1(shlVar1), .shlVar2(shlVar2),
		.lShrVar1(lShrVar1), .lShrShift(lShrShift),
		.multA(multA), .multB(multB), .lMultA(lMultA), .lMultB(lMultB),
		.subOut(subOut), .lSubOut(lSubOut), .addOut(addOut), .shlOut(shlOut),
		.lShrOut(lShrOut), .multOut(multOut), .lMultOut(lMultOut)
	);

	// Port b belongs to the host
	scratchMem #(.addrWidth(addrWidth)) ram (
		.clk(clk),
		.aRdAddr(memReadAddr), .aWrAddr(memWriteAddr), .aWrData(memOut),
		.aWrEn(memWriteEn), .aRdData(memIn),
		.bAddr(hostAddr), .bWrData(hostWrData), .bWrEn(hostWrEn), .bRdData(hostRdData)
	);

	constantRom rom (
		.clk(clk),
		.addr(constantMemAddr),
		.data(constantMemIn)
	);

endmodule

/* hdl/lspTables.hex */
// One 32-bit word per line: table2[0..63], then slope_acos[0..63], sign-extended
00007FFF
00007FD9
00007F62
00007E9D
00007D8A
00007C2A
00007A7D
00007885
00007642
000073B6
000070E3
00006DCA
00006A6E
000066D0
000062F2
00005ED7
00005A82
000055F6
00005134
00004C40
0000471D
000041CE
00003C57
000036BA
000030FC
00002B1F
00002528
00001F1A
000018F9
000012C8
00000C8C
00000648
00000000
FFFFF9B8
FFFFF374
FFFFED38
FFFFE707
FFFFE0E6
FFFFDAD8
FFFFD4E1
FFFFCF04
FFFFC946
FFFFC3A9
FFFFBE32
FFFFB8E3
FFFFB3C0
FFFFAECC
FFFFAA0A
FFFFA57E
FFFFA129
FFFF9D0E
FFFF9930
FFFF9592
FFFF9236
FFFF8F1D
FFFF8C4A
FFFF89BE
FFFF877B
FFFF8583
FFFF83D6
FFFF8276
FFFF8163
FFFF809E
FFFF8027
FFFF96F9
FFFFDD94
FFFFEB35
FFFFF11B
FFFFF45D
FFFFF674
FFFFF7DF
FFFFF8ED
FFFFF9B8
FFFFFA56
FFFFFAD6
FFFFFB3D
FFFFFB94
FFFFFBDD
FFFFFC1A
FFFFFC4E
FFFFFC7B
FFFFFCA3
FFFFFCC5
FFFFFCE3
FFFFFCFC
FFFFFD12
FFFFFD26
FFFFFD37
FFFFFD45
FFFFFD51
FFFFFD5B
FFFFFD64
FFFFFD6A
FFFFFD6F
FFFFFD72
FFFFFD74
FFFFFD74
FFFFFD72
FFFFFD6F
FFFFFD6A
FFFFFD64
FFFFFD5B
FFFFFD51
FFFFFD45
FFFFFD37
FFFFFD26
FFFFFD12
FFFFFCFC
FFFFFCE3
FFFFFCC5
FFFFFCA3
FFFFFC7B
FFFFFC4E
FFFFFC1A
FFFFFBDD
FFFFFB94
FFFFFB3D
FFFFFAD6
FFFFFA56
FFFFF9B8
FFFFF8ED
FFFFF7DF
FFFFF674
FFFFF45D
FFFFF11B
FFFFEB35
FFFFDD94
FFFF96F9

/* hdl/scratchMem.sv */
module scratchMem import g729Pkg::*; #(
	parameter int addrWidth = 12
) (
	input logic clk,
	input logic [addrWidth-1:0] aRdAddr,
	input logic [addrWidth-1:0] aWrAddr,
	input logic [longWidth-1:0] aWrData,
	input logic aWrEn,
	output logic [longWidth-1:0] aRdData,
	input logic [addrWidth-1:0] bAddr,
	input logic [longWidth-1:0] bWrData,
	input logic bWrEn,
	output logic [longWidth-1:0] bRdData
);

	logic [longWidth-1:0] mem [0:2**addrWidth-1];

	////////////////////////////////////////
	// Write side
	////////////////////////////////////////

	// Port a is written last so it wins a same-address collision
	always_ff @(posedge clk)
	begin
		if (bWrEn)
			mem[bAddr] <= bWrData;
		if (aWrEn)
			mem[aWrAddr] <= aWrData;
	end

	////////////////////////////////////////
	// Registered reads returning old data on collision
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		aRdData <= mem[aRdAddr];
	end

	always_ff @(posedge clk)
	begin
		bRdData <= mem[bAddr];
	end

endmodule

/* lspLsf.f */
hdl/g729Pkg.sv
hdl/basicOps.sv
hdl/scratchMem.sv
hdl/constantRom.sv
hdl/lspLsfConverter.sv
hdl/lspLsfTop.sv
testbench/lspLsfTb_checker.sv
testbench/lspLsfTb.sv

/* run.sh */
#!/bin/sh
# Build and run the LSP to LSF testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module lspLsfTb -f lspLsf.f -o simLspLsf
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simLspLsf +verilator+error+limit+1000 > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "Testbench failed" "$logFile"; then
	exit 1
fi
exit 0

/* testbench/lspLsfTb.sv */
module lspLsfTb import g729Pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int addrWidth = 12;
	localparam int waitLimit = 2000;
	localparam logic [31:0] lfsrSeed = 32'hf130f923;
	localparam longint maxLong = 64'sd2147483647;
	localparam longint minLong = -64'sd2147483648;

	logic clk;
	logic reset;
	logic start;
	logic [addrWidth-1:0] lspAddr;
	logic [addrWidth-1:0] lsfAddr;
	logic [addrWidth-1:0] hostAddr;
	logic [longWidth-1:0] hostWrData;
	logic hostWrEn;
	logic [longWidth-1:0] hostRdData;
	logic busy;
	logic done;

	logic [31:0] tableWords [0:127];
	logic [31:0] lfsrState;
	shortint lspVec [0:9];
	logic [15:0] expected [0:9];
	logic [15:0] firstResults [0:9];
	int doneCount;
	int testCount;
	int failedTests;
	int errorCount;
	bit timedOut;

	lspLsfTop #(.addrWidth(addrWidth)) lspLsfTop_inst (
		.clk(clk), .reset(reset), .start(start),
		.lspAddr(lspAddr), .lsfAddr(lsfAddr),
		.hostAddr(hostAddr), .hostWrData(hostWrData), .hostWrEn(hostWrEn),
		.hostRdData(hostRdData), .busy(busy), .done(done)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
	begin
		if (reset)
			doneCount <= 0;
		else if (done)
			doneCount <= doneCount + 1;
	end

	////////////////////////////////////////
	// Reference arithmetic
	////////////////////////////////////////

	function automatic longint clampWord(input longint v);
		if (v > 32767)
			return 32767;
		if (v < -32768)
			return -32768;
		return v;
	endfunction

	function automatic longint clampLong(input longint v);
		if (v > maxLong)
			return maxLong;
		if (v < minLong)
			return minLong;
		return v;
	endfunction

	// Q15 product taken from the upper half of the doubled product
	function automatic longint fracMult(input longint a, input longint b);
		return clampWord((a * b) >>> 15);
	endfunction

	function automatic longint doubledProduct(input longint a, input longint b);
		return clampLong(2 * a * b);
	endfunction

	function automatic longint shiftLeftSat(input longint v, input int n);
		return clampWord(v * (longint'(1) << n));
	endfunction

	function automatic longint lowHalf(input longint v);
		return longint'(shortint'(v));
	endfunction

	function automatic longint tableEntry(input int idx);
		return longint'(shortint'(tableWords[idx][15:0]));
	endfunction

	// Search, offset, slope term and scaling for all ten coefficients
	task automatic modelConvert();
		int ind;
		longint offset;
		longint lTmp;
		longint freq;
		ind = 63;
		for (int k = lspOrder - 1; k >= 0; k--)
		begin
			while (ind > 0 && clampWord(tableEntry(ind) - longint'(lspVec[k])) < 0)
				ind = ind - 1;
			offset = clampWord(longint'(lspVec[k]) - tableEntry(ind));
			lTmp = doubledProduct(tableEntry(64 + ind), offset);
			freq = clampWord(shiftLeftSat(ind, int'(indShift))
				+ lowHalf(lTmp >>> int'(slopeShift)));
			expected[k] = 16'(fracMult(freq, longint'(lsfScale)));
		end
	endtask

	////////////////////////////////////////
	// Random vectors
	////////////////////////////////////////

	function automatic bit nextRandomBit();
		bit feedback;
		feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
		lfsrState = {lfsrState[30:0], feedback};
		return feedback;
	endfunction

	function automatic logic [15:0] randomHalfWord();
		logic [15:0] v;
		for (int b = 0; b < 16; b++)
			v[b] = nextRandomBit();
		return v;
	endfunction

	// Largest pair first as the codec orders them
	task automatic randomVector();
		shortint swap;
		for (int k = 0; k < lspOrder; k++)
			lspVec[k] = shortint'(randomHalfWord());
		for (int a = 0; a < lspOrder - 1; a++)
			for (int b = 0; b < lspOrder - 1 - a; b++)
				if (lspVec[b] < lspVec[b + 1])
				begin
					swap = lspVec[b];
					lspVec[b] = lspVec[b + 1];
					lspVec[b + 1] = swap;
				end
	endtask

	////////////////////////////////////////
	// Host port access
	////////////////////////////////////////

	task automatic writeWord(input logic [addrWidth-1:0] addr, input logic [31:0] data);
		@(negedge clk);
		hostAddr = addr;
		hostWrData = data;
		hostWrEn = 1'b1;
		@(negedge clk);
		hostWrEn = 1'b0;
	endtask

	task automatic readWord(input logic [addrWidth-1:0] addr, output logic [31:0] data);
		@(negedge clk);
		hostAddr = addr;
		@(negedge clk);
		data = hostRdData;
	endtask

	task automatic checkWord(input string name, input int idx, input logic [31:0] want,
			input logic [31:0] got);
		assert (got === want)
		else
		begin
			$display("FAILED %s lsf[%0d] expected %h actual %h", name, idx, want, got);
			errorCount++;
		end
	endtask

	task automatic reportTest(input string name, input int errorsBefore);
		testCount++;
		if (errorCount == errorsBefore)
			$display("Test %s: ok", name);
		else
		begin
			$display("Test %s: %0d errors", name, errorCount - errorsBefore);
			failedTests++;
		end
	endtask

	// Load, start, wait for done, read back and compare with the model
	task automatic runConversion(input string name, input logic [addrWidth-1:0] lspBase,
			input logic [addrWidth-1:0] lsfBase, input bit extraStart);
		int errorsBefore;
		int doneBefore;
		int cycles;
		bit seen;
		logic [31:0] readBack;
		errorsBefore = errorCount;
		doneBefore = doneCount;
		modelConvert();
		for (int k = 0; k < lspOrder; k++)
			writeWord(lspBase + addrWidth'(k), 32'(lspVec[k]));
		@(negedge clk);
		lspAddr = lspBase;
		lsfAddr = lsfBase;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		assert (busy === 1'b1)
		else
		begin
			$display("FAILED %s busy after start expected %0d actual %0d", name, 1, busy);
			errorCount++;
		end
		if (extraStart)
		begin
			// Second pulse lands while busy
			@(negedge clk);
			start = 1'b1;
			@(negedge clk);
			start = 1'b0;
		end
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < waitLimit)
		begin
			@(negedge clk);
			cycles++;
			if (doneCount != doneBefore)
				seen = 1'b1;
		end
		if (!seen)
		begin
			$display("Test %s timed out: no done within %0d cycles", name, waitLimit);
			timedOut = 1'b1;
			errorCount++;
		end
		else
		begin
			repeat (4) @(negedge clk);
			assert (doneCount == doneBefore + 1)
			else
			begin
				$display("FAILED %s done pulses expected %0d actual %0d", name, 1,
					doneCount - doneBefore);
				errorCount++;
			end
			assert (busy === 1'b0)
			else
			begin
				$display("FAILED %s busy after done expected %0d actual %0d", name, 0, busy);
				errorCount++;
			end
			for (int k = 0; k < lspOrder; k++)
			begin
				readWord(lsfBase + addrWidth'(k), readBack);
				checkWord(name, k, {16'h0000, expected[k]}, readBack);
			end
		end
		reportTest(name, errorsBefore);
	endtask

	task automatic checkPreserved(input string name, input logic [addrWidth-1:0] base);
		int errorsBefore;
		logic [31:0] readBack;
		errorsBefore = errorCount;
		for (int k = 0; k < lspOrder; k++)
		begin
			readWord(base + addrWidth'(k), readBack);
			checkWord(name, k, {16'h0000, firstResults[k]}, readBack);
		end
		reportTest(name, errorsBefore);
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial
	begin
		reset = 1'b1;
		start = 1'b0;
		lspAddr = '0;
		lsfAddr = '0;
		hostAddr = '0;
		hostWrData = '0;
		hostWrEn = 1'b0;
		lfsrState = lfsrSeed;
		testCount = 0;
		failedTests = 0;
		errorCount = 0;
		timedOut = 1'b0;
		$readmemh("hdl/lspTables.hex", tableWords);
		repeat (8) @(negedge clk);
		reset = 1'b0;

		lspVec = '{30000, 26000, 21000, 15000, 8000, 0, -8000, -15000, -21000, -26000};
		runConversion("typical", 12'h100, 12'h200, 1'b0);
		firstResults = expected;

		// All above table2[1] so the search ends at index 0
		lspVec = '{32767, 32765, 32760, 32755, 32750, 32745, 32740, 32735, 32731, 32730};
		if (!timedOut)
			runConversion("nearOne", 12'h110, 12'h120, 1'b0);

		lspVec = '{32767, 32767, 32767, 32767, 32767, -32767, -32767, -32767, -32767, -32767};
		if (!timedOut)
			runConversion("extremes", 12'h130, 12'h140, 1'b0);

		lspVec = '{31000, 28000, 23000, 17000, 10000, 3000, -4000, -12000, -20000, -29000};
		if (!timedOut)
			runConversion("secondBlock", 12'h300, 12'h400, 1'b0);
		if (!timedOut)
			checkPreserved("firstBlockKept", 12'h200);

		for (int r = 0; r < 4; r++)
		begin
			randomVector();
			if (!timedOut)
				runConversion($sformatf("random%0d", r), 12'h500, 12'h510, 1'b1);
		end

		$display("Tests run: %0d, tests failed: %0d, check errors: %0d, %s %0d",
			testCount, failedTests, errorCount, "protocol violations:",
			lspLsfTop_inst.protocolCheck.violationCount);
		if (errorCount == 0 && failedTests == 0 && !timedOut
				&& lspLsfTop_inst.protocolCheck.violationCount == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

/* testbench/lspLsfTb_checker.sv */
module lspLsfTb_checker import g729Pkg::*; #(
	parameter int addrWidth = 12
) (
	input logic clk,
	input logic reset,
	input logic busy,
	input logic done,
	input logic memWriteEn,
	input logic [addrWidth-1:0] memWriteAddr,
	input logic [addrWidth-1:0] lsfAddr
);

	timeunit 1ns;
	timeprecision 100ps;

	int violationCount = 0;

	////////////////////////////////////////
	// Handshake
	////////////////////////////////////////

	donePulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
	else
	begin
		$error("done stayed high for more than one cycle");
		violationCount++;
	end

	writeWhileBusy: assert property (@(posedge clk) disable iff (reset) memWriteEn |-> busy)
	else
	begin
		$error("memory write while the converter was idle");
		violationCount++;
	end

	// Writes stay inside the ten words of the lsf block
	writeInBlock: assert property (@(posedge clk) disable iff (reset)
		memWriteEn |-> (memWriteAddr[addrWidth-1:4] == lsfAddr[addrWidth-1:4]
			&& memWriteAddr[3:0] < lspOrder))
	else
	begin
		$error("write address %h outside the lsf block at %h", memWriteAddr, lsfAddr);
		violationCount++;
	end

	resetQuiet: assert property (@(posedge clk) reset |=> (!busy && !done && !memWriteEn))
	else
	begin
		$error("busy, done or a write was active after reset");
		violationCount++;
	end

endmodule

bind lspLsfTop lspLsfTb_checker #(.addrWidth(addrWidth)) protocolCheck (
	.clk(clk),
	.reset(reset),
	.busy(busy),
	.done(done),
	.memWriteEn(memWriteEn),
	.memWriteAddr(memWriteAddr),
	.lsfAddr(lsfAddr)
);
